/* verilog/wb_macros.svh */
`ifndef WB_MACROS_SVH
`define WB_MACROS_SVH

// datapath and address width
`define CPU_WIDTH 32

// instruction word width
`define INS_WIDTH 32

// integer register index width
`define REG_ADDRW 5

// csr address width
`define CSR_ADDRW 12

// data memory word address width, 256 words
`define DMEM_AW 8

`endif

/* verilog/wb_pkg.sv */
`default_nettype none
`include "wb_macros.svh"

package wb_pkg;

  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } mem_op_e;

  // item entering the memory stage
  typedef struct packed {
    logic [`CPU_WIDTH-1:0] pc;
    logic [`INS_WIDTH-1:0] ins;
    // alu result, also the load/store address
    logic [`CPU_WIDTH-1:0] exres;
    logic [`CPU_WIDTH-1:0] stdata;
    mem_op_e               mem_op;
    logic [`REG_ADDRW-1:0] rdid;
    logic                  rdwen;
    logic [`CSR_ADDRW-1:0] csrdid;
    logic                  csrdwen;
    logic [`CPU_WIDTH-1:0] csrd;
    logic                  nop;
  } exu_to_lsu_t;

  // item leaving the memory stage
  typedef struct packed {
    logic [`CPU_WIDTH-1:0] pc;
    logic [`INS_WIDTH-1:0] ins;
    logic [`CPU_WIDTH-1:0] exres;
    logic [`CPU_WIDTH-1:0] lsres;
    logic                  lden;
    logic [`REG_ADDRW-1:0] rdid;
    logic                  rdwen;
    logic [`CSR_ADDRW-1:0] csrdid;
    logic                  csrdwen;
    logic [`CPU_WIDTH-1:0] csrd;
    logic                  nop;
  } lsu_to_wbu_t;

  // wishbone classic, master side
  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [`CPU_WIDTH-1:0] adr;
    logic [`CPU_WIDTH-1:0] dat_w;
  } wb_req_t;

  // wishbone classic, slave side
  typedef struct packed {
    logic                  ack;
    logic [`CPU_WIDTH-1:0] dat_r;
  } wb_rsp_t;

  typedef struct packed {
    logic                  en;
    logic [`REG_ADDRW-1:0] id;
    logic [`CPU_WIDTH-1:0] data;
  } rf_wr_t;

  typedef struct packed {
    logic                  en;
    logic [`CSR_ADDRW-1:0] id;
    logic [`CPU_WIDTH-1:0] data;
  } csr_wr_t;

  typedef struct packed {
    logic                  commit;
    logic [`CPU_WIDTH-1:0] pc;
    logic [`INS_WIDTH-1:0] ins;
    logic                  nop;
  } retire_t;

endpackage

`default_nettype wire

/* verilog/pipe_reg.sv */
`default_nettype none

module pipe_reg #(
  parameter type T = logic
) (
  input  wire logic i_clk,
  input  wire logic i_rst,
  input  wire logic i_flush,
  input  wire logic i_valid,
  output logic      o_ready,
  input  wire T     i_data,
  output logic      o_valid,
  input  wire logic i_ready,
  output T          o_data
);

  // free slot, or the held item leaves this cycle
  assign o_ready = !o_valid || i_ready;

  always_ff @(posedge i_clk) begin
    if (i_rst || i_flush) begin
      o_valid <= 1'b0;
    end else if (o_ready) begin
      o_valid <= i_valid;
    end
  end

  // payload only moves on a transfer
  always_ff @(posedge i_clk) begin
    if (i_valid && o_ready) begin
      o_data <= i_data;
    end
  end

endmodule

`default_nettype wire

/* verilog/lsu.sv */
`default_nettype none
`include "wb_macros.svh"

module lsu (
  input  wire logic                i_clk,
  input  wire logic                i_rst,
  input  wire logic                i_flush,
  input  wire logic                i_valid,
  output logic                     o_ready,
  input  wire wb_pkg::exu_to_lsu_t i_item,
  output logic                     o_valid,
  input  wire logic                i_ready,
  output wb_pkg::lsu_to_wbu_t      o_item,
  output wb_pkg::wb_req_t          o_wb,
  input  wire wb_pkg::wb_rsp_t     i_wb
);

  typedef enum logic [1:0] {S_IDLE, S_BUSY, S_DONE} state_e;

  wb_pkg::exu_to_lsu_t   q_item;
  logic                  q_valid;
  logic                  q_take;
  state_e                state;
  logic                  killed;
  logic                  is_mem;
  logic                  done;
  logic                  req_we;
  logic [`CPU_WIDTH-1:0] req_adr;
  logic [`CPU_WIDTH-1:0] req_dat;
  logic [`CPU_WIDTH-1:0] ld_data;

  pipe_reg #(
    .T (wb_pkg::exu_to_lsu_t)
  ) u_hold (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_flush (i_flush),
    .i_valid (i_valid),
    .o_ready (o_ready),
    .i_data  (i_item),
    .o_valid (q_valid),
    .i_ready (q_take),
    .o_data  (q_item)
  );

  assign is_mem = q_item.mem_op != wb_pkg::MEM_NONE;
  // non-memory items pass straight through
  assign done    = !is_mem || (state == S_DONE);
  assign o_valid = q_valid && done;
  assign q_take  = done && i_ready;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state  <= S_IDLE;
      killed <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (q_valid && is_mem && !i_flush) begin
            state <= S_BUSY;
          end
        end
        S_BUSY: begin
          // a flushed access still runs to its ack, then is dropped
          if (i_wb.ack) begin
            state  <= (killed || i_flush) ? S_IDLE : S_DONE;
            killed <= 1'b0;
          end else if (i_flush) begin
            killed <= 1'b1;
          end
        end
        S_DONE: begin
          if (i_flush || i_ready) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // request fields frozen for the whole bus cycle
  always_ff @(posedge i_clk) begin
    if (state == S_IDLE) begin
      req_we  <= q_item.mem_op == wb_pkg::MEM_STORE;
      req_adr <= q_item.exres;
      req_dat <= q_item.stdata;
    end
    if (state == S_BUSY && i_wb.ack) begin
      ld_data <= i_wb.dat_r;
    end
  end

  assign o_wb = '{cyc: state == S_BUSY, stb: state == S_BUSY, we: req_we,
                  adr: req_adr, dat_w: req_dat};

  always_comb begin
    o_item.pc      = q_item.pc;
    o_item.ins     = q_item.ins;
    o_item.exres   = q_item.exres;
    o_item.lsres   = ld_data;
    o_item.lden    = q_item.mem_op == wb_pkg::MEM_LOAD;
    o_item.rdid    = q_item.rdid;
    // stores never write rd
    o_item.rdwen   = q_item.rdwen && (q_item.mem_op != wb_pkg::MEM_STORE);
    o_item.csrdid  = q_item.csrdid;
    o_item.csrdwen = q_item.csrdwen;
    o_item.csrd    = q_item.csrd;
    o_item.nop     = q_item.nop;
  end

endmodule

`default_nettype wire

/* verilog/wbu.sv */
`default_nettype none
`include "wb_macros.svh"

module wbu (
  input  wire logic                i_clk,
  input  wire logic                i_rst,
  input  wire logic                i_flush,
  input  wire logic                i_intr,
  input  wire logic                i_valid,
  output logic                     o_ready,
  input  wire wb_pkg::lsu_to_wbu_t i_item,
  output logic                     o_valid,
  input  wire logic                i_ready,
  output wb_pkg::rf_wr_t           o_rf,
  output wb_pkg::csr_wr_t          o_csr,
  output wb_pkg::retire_t          o_retire
);

  wb_pkg::lsu_to_wbu_t   h_item;
  logic                  commit;
  logic [`CPU_WIDTH-1:0] rd_data;

  pipe_reg #(
    .T (wb_pkg::lsu_to_wbu_t)
  ) u_hold (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_flush (i_flush),
    .i_valid (i_valid),
    .o_ready (o_ready),
    .i_data  (i_item),
    .o_valid (o_valid),
    .i_ready (i_ready),
    .o_data  (h_item)
  );

  // an item leaving under interrupt is consumed but not committed
  assign commit  = o_valid && i_ready && !i_intr;
  assign rd_data = h_item.lden ? h_item.lsres : h_item.exres;

  assign o_rf = '{en: commit && h_item.rdwen, id: h_item.rdid, data: rd_data};

  assign o_csr = '{en: commit && h_item.csrdwen, id: h_item.csrdid,
                   data: h_item.csrd};

  assign o_retire = '{commit: commit, pc: h_item.pc, ins: h_item.ins,
                      nop: h_item.nop};

endmodule

`default_nettype wire

/* verilog/dmem_wb.sv */
`default_nettype none
`include "wb_macros.svh"

module dmem_wb (
  input  wire logic            i_clk,
  input  wire logic            i_rst,
  input  wire wb_pkg::wb_req_t i_wb,
  output wb_pkg::wb_rsp_t      o_wb
);

  logic [`CPU_WIDTH-1:0] mem [2**`DMEM_AW];
  logic [`DMEM_AW-1:0]   idx;
  logic                  access;
  logic                  ack_q;
  logic [`CPU_WIDTH-1:0] rd_q;

  // word addressed, byte offset bits ignored
  assign idx = i_wb.adr[`DMEM_AW+1:2];

  // one access per strobe, the ack cycle itself is not a new request
  assign access = i_wb.cyc && i_wb.stb && !ack_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge i_clk) begin
    if (access) begin
      if (i_wb.we) begin
        mem[idx] <= i_wb.dat_w;
      end
      rd_q <= mem[idx];
    end
  end

  assign o_wb = '{ack: ack_q, dat_r: rd_q};

endmodule

`default_nettype wire

/* verilog/mem_wb_top.sv */
`default_nettype none

module mem_wb_top (
  input  wire logic                i_clk,
  input  wire logic                i_rst,
  input  wire logic                i_flush,
  input  wire logic                i_intr,
  input  wire logic                i_valid,
  output logic                     o_ready,
  input  wire wb_pkg::exu_to_lsu_t i_item,
  output logic                     o_valid,
  input  wire logic                i_ready,
  output wb_pkg::rf_wr_t           o_rf,
  output wb_pkg::csr_wr_t          o_csr,
  output wb_pkg::retire_t          o_retire
);

  // lsu to wbu handshake
  logic                lsu_valid;
  logic                wbu_ready;
  wb_pkg::lsu_to_wbu_t lsu_item;

  // data memory bus
  wb_pkg::wb_req_t     wb_req;
  wb_pkg::wb_rsp_t     wb_rsp;

  lsu u_lsu (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_flush (i_flush),
    .i_valid (i_valid),
    .o_ready (o_ready),
    .i_item  (i_item),
    .o_valid (lsu_valid),
    .i_ready (wbu_ready),
    .o_item  (lsu_item),
    .o_wb    (wb_req),
    .i_wb    (wb_rsp)
  );

  dmem_wb u_dmem (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_wb  (wb_req),
    .o_wb  (wb_rsp)
  );

  wbu u_wbu (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_flush  (i_flush),
    .i_intr   (i_intr),
    .i_valid  (lsu_valid),
    .o_ready  (wbu_ready),
    .i_item   (lsu_item),
    .o_valid  (o_valid),
    .i_ready  (i_ready),
    .o_rf     (o_rf),
    .o_csr    (o_csr),
    .o_retire (o_retire)
  );

endmodule

`default_nettype wire

/* test/tb_mem_wb.sv */
`default_nettype none
`include "wb_macros.svh"

module tb_mem_wb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int DRAIN_LIMIT = 200;
  localparam int MODE_ALU    = 0;
  localparam int MODE_ALL    = 1;
  localparam int MODE_LOAD   = 2;

  logic                  i_clk;
  logic                  i_rst;
  logic                  i_flush;
  logic                  i_intr;
  logic                  i_valid;
  logic                  o_ready;
  wb_pkg::exu_to_lsu_t   i_item;
  logic                  o_valid;
  logic                  i_ready;
  wb_pkg::rf_wr_t        o_rf;
  wb_pkg::csr_wr_t       o_csr;
  wb_pkg::retire_t       o_retire;

  // stimulus state
  logic [15:0]           lfsr;
  logic                  xfer;
  bit                    gen_on;
  int                    mem_mode;
  bit                    rnd_ready;
  bit                    rnd_intr;
  bit                    rnd_flush;
  int unsigned           drv_seq;

  // reference model with one entry per accepted item
  wb_pkg::exu_to_lsu_t   exp_q[$];
  logic [`CPU_WIDTH-1:0] ld_q[$];
  int unsigned           seq_q[$];
  int unsigned           acc_seq;
  // items numbered below this were accepted before the latest flush
  int unsigned           flush_mark;
  logic [`CPU_WIDTH-1:0] mem_model [2**`DMEM_AW];
  bit                    written [2**`DMEM_AW];
  logic [`DMEM_AW-1:0]   written_idx[$];

  mem_wb_top u_dut (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_flush  (i_flush),
    .i_intr   (i_intr),
    .i_valid  (i_valid),
    .o_ready  (o_ready),
    .i_item   (i_item),
    .o_valid  (o_valid),
    .i_ready  (i_ready),
    .o_rf     (o_rf),
    .o_csr    (o_csr),
    .o_retire (o_retire)
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  task automatic fail_run();
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail at %0t: %s expected %b actual %b", $time, name, exp, act);
      fail_run();
    end
  endtask

  task automatic check_rf(input wb_pkg::rf_wr_t exp, input wb_pkg::rf_wr_t act);
    if (act !== exp) begin
      $display("Fail at %0t: o_rf expected %h actual %h", $time, exp, act);
      fail_run();
    end
  endtask

  task automatic check_csr(input wb_pkg::csr_wr_t exp, input wb_pkg::csr_wr_t act);
    if (act !== exp) begin
      $display("Fail at %0t: o_csr expected %h actual %h", $time, exp, act);
      fail_run();
    end
  endtask

  task automatic check_retire(input wb_pkg::retire_t exp, input wb_pkg::retire_t act);
    if (act !== exp) begin
      $display("Fail at %0t: o_retire expected %h actual %h", $time, exp, act);
      fail_run();
    end
  endtask

  // galois lfsr for x^16 + x^14 + x^13 + x^11 + 1
  // stepped once for each bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    int          b;
    v = '0;
    for (b = 0; b < n; b++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? 16'hB400 : 16'h0000);
    end
    return v;
  endfunction

  function automatic wb_pkg::exu_to_lsu_t make_item();
    wb_pkg::exu_to_lsu_t it;
    logic [1:0]          kind;
    logic [`DMEM_AW-1:0] idx;
    // pc is unique per item so a retire can be matched to its entry
    it.pc      = `CPU_WIDTH'(drv_seq << 2);
    drv_seq    = drv_seq + 1;
    it.ins     = take_bits(`INS_WIDTH);
    it.exres   = take_bits(`CPU_WIDTH);
    it.stdata  = take_bits(`CPU_WIDTH);
    it.rdid    = `REG_ADDRW'(take_bits(`REG_ADDRW));
    it.rdwen   = take_bits(1) != 0;
    it.csrdid  = `CSR_ADDRW'(take_bits(`CSR_ADDRW));
    it.csrdwen = take_bits(1) != 0;
    it.csrd    = take_bits(`CPU_WIDTH);
    it.nop     = take_bits(1) != 0;
    it.mem_op  = wb_pkg::MEM_NONE;
    kind       = 2'(take_bits(2));
    if (mem_mode != MODE_ALU && kind == 2'd1 && written_idx.size() > 0) begin
      // loads only read words that a store has written
      idx       = written_idx[take_bits(8) % written_idx.size()];
      it.mem_op = wb_pkg::MEM_LOAD;
      it.exres  = {{(`CPU_WIDTH-`DMEM_AW-2){1'b0}}, idx, 2'b00};
    end else if (mem_mode == MODE_ALL && kind == 2'd2) begin
      idx       = `DMEM_AW'(take_bits(`DMEM_AW));
      it.mem_op = wb_pkg::MEM_STORE;
      it.exres  = {{(`CPU_WIDTH-`DMEM_AW-2){1'b0}}, idx, 2'b00};
    end
    return it;
  endfunction

  task automatic drive_inputs();
    // an offered item stays until it is taken
    if (xfer || !i_valid) begin
      if (gen_on && take_bits(2) != 0) begin
        i_valid <= 1'b1;
        i_item  <= make_item();
      end else begin
        i_valid <= 1'b0;
      end
    end
    i_ready <= rnd_ready ? (take_bits(2) != 0) : 1'b1;
    i_intr  <= rnd_intr ? (take_bits(3) == 0) : 1'b0;
    i_flush <= rnd_flush ? (take_bits(4) == 0) : 1'b0;
  endtask

  task automatic accept_one();
    logic [`DMEM_AW-1:0]   idx;
    logic [`CPU_WIDTH-1:0] ldv;
    idx = i_item.exres[`DMEM_AW+1:2];
    ldv = '0;
    // memory order equals acceptance order in a single-issue lsu
    if (i_item.mem_op == wb_pkg::MEM_STORE) begin
      mem_model[idx] = i_item.stdata;
      if (!written[idx]) begin
        written[idx] = 1'b1;
        written_idx.push_back(idx);
      end
    end else if (i_item.mem_op == wb_pkg::MEM_LOAD) begin
      ldv = mem_model[idx];
    end
    exp_q.push_back(i_item);
    ld_q.push_back(ldv);
    seq_q.push_back(acc_seq);
    acc_seq = acc_seq + 1;
  endtask

  task automatic retire_one();
    wb_pkg::exu_to_lsu_t   it;
    logic [`CPU_WIDTH-1:0] ldv;
    logic                  commit;
    wb_pkg::retire_t       exp_ret;
    wb_pkg::rf_wr_t        exp_rf;
    wb_pkg::csr_wr_t       exp_csr;
    // skip older items that a flush removed
    while (exp_q.size() > 0 && seq_q[0] < flush_mark) begin
      exp_q.delete(0);
      ld_q.delete(0);
      seq_q.delete(0);
    end
    if (exp_q.size() == 0) begin
      $display("item with pc %h left write-back at %0t but none was outstanding",
               o_retire.pc, $time);
      fail_run();
    end else begin
      it  = exp_q.pop_front();
      ldv = ld_q.pop_front();
      seq_q.delete(0);
      commit         = !i_intr;
      exp_ret.commit = commit;
      exp_ret.pc     = it.pc;
      exp_ret.ins    = it.ins;
      exp_ret.nop    = it.nop;
      exp_rf.en      = commit && it.rdwen && (it.mem_op != wb_pkg::MEM_STORE);
      exp_rf.id      = it.rdid;
      exp_rf.data    = (it.mem_op == wb_pkg::MEM_LOAD) ? ldv : it.exres;
      exp_csr.en     = commit && it.csrdwen;
      exp_csr.id     = it.csrdid;
      exp_csr.data   = it.csrd;
      check_retire(exp_ret, o_retire);
      check_rf(exp_rf, o_rf);
      check_csr(exp_csr, o_csr);
    end
  endtask

  task automatic sample_cycle();
    if (o_valid && i_ready) begin
      retire_one();
    end else begin
      check_bit("o_retire.commit", 1'b0, o_retire.commit);
      check_bit("o_rf.en", 1'b0, o_rf.en);
      check_bit("o_csr.en", 1'b0, o_csr.en);
    end
    xfer = i_valid && o_ready;
    if (xfer) begin
      accept_one();
    end
    if (i_flush) begin
      flush_mark = acc_seq;
    end
  endtask

  task automatic run_cycles(input int n);
    int k;
    for (k = 0; k < n; k++) begin
      @(posedge i_clk);
      drive_inputs();
      @(negedge i_clk);
      sample_cycle();
    end
  endtask

  function automatic bit has_live();
    if (seq_q.size() == 0) begin
      return 1'b0;
    end else begin
      return seq_q[seq_q.size()-1] >= flush_mark;
    end
  endfunction

  task automatic drain_pipe();
    int waited;
    gen_on    = 1'b0;
    rnd_flush = 1'b0;
    waited    = 0;
    while (i_valid || has_live()) begin
      if (waited >= DRAIN_LIMIT) begin
        $display("timeout: pipeline still held items after %0d cycles at %0t",
                 DRAIN_LIMIT, $time);
        fail_run();
      end
      run_cycles(1);
      waited++;
    end
    // whatever is left was lost to a flush
    exp_q.delete();
    ld_q.delete();
    seq_q.delete();
  endtask

  task automatic run_phase(input int n, input int mode, input bit r_ready,
                           input bit r_intr, input bit r_flush);
    mem_mode  = mode;
    rnd_ready = r_ready;
    rnd_intr  = r_intr;
    rnd_flush = r_flush;
    gen_on    = 1'b1;
    run_cycles(n);
    drain_pipe();
  endtask

  initial begin
    lfsr       = 16'd56322;
    i_rst      = 1'b1;
    i_flush    = 1'b0;
    i_intr     = 1'b0;
    i_valid    = 1'b0;
    i_ready    = 1'b0;
    i_item     = '0;
    xfer       = 1'b0;
    gen_on     = 1'b0;
    mem_mode   = MODE_ALU;
    rnd_ready  = 1'b0;
    rnd_intr   = 1'b0;
    rnd_flush  = 1'b0;
    drv_seq    = 0;
    acc_seq    = 0;
    flush_mark = 0;
    repeat (2) @(posedge i_clk);
    i_rst   <= 1'b0;
    i_ready <= 1'b1;
    @(negedge i_clk);
    check_bit("o_valid", 1'b0, o_valid);
    check_bit("o_retire.commit", 1'b0, o_retire.commit);
    check_bit("o_rf.en", 1'b0, o_rf.en);
    check_bit("o_csr.en", 1'b0, o_csr.en);
    check_bit("o_ready", 1'b1, o_ready);
    // alu items only without stalls
    run_phase(60, MODE_ALU, 1'b0, 1'b0, 1'b0);
    // loads and stores under back-pressure and interrupts
    run_phase(400, MODE_ALL, 1'b1, 1'b1, 1'b0);
    // alu items and loads with flushes
    run_phase(400, MODE_LOAD, 1'b1, 1'b1, 1'b1);
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+verilog
verilog/wb_pkg.sv
verilog/pipe_reg.sv
verilog/lsu.sv
verilog/wbu.sv
verilog/dmem_wb.sv
verilog/mem_wb_top.sv
test/tb_mem_wb.sv
